// File: filelist.f
+incdir+.
secp256k1_pkg.sv
fe_op_pkg.sv
secp256k1_mod.sv
fe_mul_path.sv
fe_addsub_path.sv
fe_result_merge.sv
fe_alu_top.sv
fe_alu_tb.sv

// File: Makefile
# Verilator build and run of the field unit testbench

VERILATOR ?= verilator
TOP       ?= fe_alu_tb
USE_MULT  ?= 0
BUILD_DIR ?= obj_dir
FILELIST  ?= filelist.f
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

# the run passes only if the pass message shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GUSE_MULT=$(USE_MULT) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "=== PASS ==="

clean:
	rm -rf $(BUILD_DIR)

// File: fe_alu_tb_util.svh
// testbench xorshift generator, reference model of the field operations and check counters
`ifndef FE_ALU_TB_UTIL_SVH
`define FE_ALU_TB_UTIL_SVH

int unsigned rng = 32'h75734f61;     // operand and op code stream
int unsigned rdy_rng = 32'h75734f61; // separate stream for the i_rdy pulses
int chk_cnt = 0;                     // results compared
int err_cnt = 0;                     // failed checks

function automatic int unsigned xorshift32(input int unsigned x);
  x ^= x << 13;
  x ^= x >> 17;
  x ^= x << 5;
  return x;
endfunction

// eight random words make one operand, folded once so it lies below p
function automatic secp256k1_pkg::fe_t rand_fe();
  secp256k1_pkg::fe_t r;
  r = '0;
  for (int i = 0; i < 8; i++) begin
    rng = xorshift32(rng);
    r = {r[223:0], rng};
  end
  return (r >= secp256k1_pkg::p_eq) ? r - secp256k1_pkg::p_eq : r; // r is below 2p
endfunction

// plain 512-bit arithmetic followed by a remainder modulo p
function automatic secp256k1_pkg::fe_t ref_result(input fe_op_pkg::fe_op_e op,
                                                  input secp256k1_pkg::fe_t a,
                                                  input secp256k1_pkg::fe_t b);
  logic [511:0] a_w;
  logic [511:0] b_w;
  logic [511:0] p_w;
  logic [511:0] r;
  a_w = {256'b0, a};
  b_w = {256'b0, b};
  p_w = {256'b0, secp256k1_pkg::p_eq};
  case (op)
    fe_op_pkg::OP_MUL: r = (a_w * b_w) % p_w;
    fe_op_pkg::OP_SUB: r = (a_w + p_w - b_w) % p_w; // adding p keeps the value positive
    default:           r = (a_w + b_w) % p_w;       // the unused code behaves as an add
  endcase
  return r[255:0];
endfunction

// an error comes in on i_err or from an operand outside the field
function automatic logic ref_err(input secp256k1_pkg::fe_t a, input secp256k1_pkg::fe_t b,
                                 input logic err);
  return err | (a >= secp256k1_pkg::p_eq) | (b >= secp256k1_pkg::p_eq);
endfunction

`endif

// File: fe_alu_tb.sv
// testbench for the field unit with clock, reset, stimulus, checks, watchdog and summary
`include "fe_defs.svh"

module fe_alu_tb #(
  parameter int USE_MULT = `FE_USE_MULT
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_OPS     = 190; // operations over all tests
  localparam int STALL_CYC = 400; // budget for i_rdy stalls and drain gaps

  logic i_clk, i_rst, i_val, i_err, i_rdy;
  logic o_rdy, o_val, o_err;
  fe_op_pkg::fe_op_e i_op;
  secp256k1_pkg::fe_t i_a, i_b, o_dat;
  logic [`FE_CTL_BITS-1:0] i_ctl, o_ctl;
  logic [`FE_CTL_BITS-1:0] tag = '0; // next tag to issue
  logic rdy_rand = 1'b0;             // random back-pressure on i_rdy
  logic lat_chk = 1'b1;              // latency is exactly 5 only while i_rdy stays high
  int cyc = 0;
  secp256k1_pkg::fe_t q_dat[$];      // expected results in issue order
  logic [`FE_CTL_BITS-1:0] q_ctl[$];
  logic q_err[$];
  int q_cyc[$];                      // cycle of acceptance

  `include "fe_alu_tb_util.svh"

  fe_alu_top #(.USE_MULT(USE_MULT)) dut0 (
    .i_clk (i_clk), .i_rst (i_rst), .i_val (i_val), .i_op (i_op), .i_a (i_a), .i_b (i_b),
    .i_ctl (i_ctl), .i_err (i_err), .i_rdy (i_rdy), .o_rdy (o_rdy), .o_val (o_val),
    .o_dat (o_dat), .o_ctl (o_ctl), .o_err (o_err)
  );

  initial begin
    i_clk = 1'b0;
    forever #10 i_clk = ~i_clk;
  end

  always @(posedge i_clk) begin
    rdy_rng = xorshift32(rdy_rng);
    i_rdy <= rdy_rand ? rdy_rng[0] : 1'b1; // pulses only during the stall test
  end

  // all values here are the ones settled before the edge
  always @(posedge i_clk) begin
    logic e_err;
    cyc = cyc + 1;
    if (!i_rst) begin
      if (i_val && o_rdy) begin
        q_dat.push_back(ref_result(i_op, i_a, i_b));
        q_ctl.push_back(i_ctl);
        q_err.push_back(ref_err(i_a, i_b, i_err));
        q_cyc.push_back(cyc);
      end
      if (o_val && !i_rdy) begin
        assert (!o_rdy) else begin
          $display("o_rdy is high while the output register is held");
          err_cnt++;
        end
      end
      if (o_val && i_rdy) begin
        chk_cnt++;
        assert (q_dat.size() != 0) else begin
          $display("a result came out with no operation outstanding");
          err_cnt++;
        end
        if (q_dat.size() != 0) begin
          e_err = q_err[0];
          if (!e_err) begin // the data of a flagged operation is not defined
            assert (o_dat == q_dat[0]) else begin
              $display("mismatch o_dat exp %h got %h", q_dat[0], o_dat);
              err_cnt++;
            end
          end
          assert (o_ctl == q_ctl[0]) else begin
            $display("mismatch o_ctl exp %h got %h", q_ctl[0], o_ctl);
            err_cnt++;
          end
          assert (o_err == e_err) else begin
            $display("mismatch o_err exp %h got %h", e_err, o_err);
            err_cnt++;
          end
          if (lat_chk) begin
            assert (cyc - q_cyc[0] == 5) else begin
              $display("result came %0d cycles after its operation, not 5", cyc - q_cyc[0]);
              err_cnt++;
            end
          end
          void'(q_dat.pop_front());
          void'(q_ctl.pop_front());
          void'(q_err.pop_front());
          void'(q_cyc.pop_front());
        end
      end
    end
  end

  // present one operation and hold it until the DUT takes it
  task automatic issue(input fe_op_pkg::fe_op_e op, input secp256k1_pkg::fe_t a,
                       input secp256k1_pkg::fe_t b, input logic err);
    i_val <= 1'b1;
    i_op  <= op;
    i_a   <= a;
    i_b   <= b;
    i_err <= err;
    i_ctl <= tag;
    tag = tag + 1'b1;
    @(posedge i_clk);
    while (!o_rdy) @(posedge i_clk);
  endtask

  task automatic end_test(input string name, input int errs0);
    int n;
    n = 0;
    i_val <= 1'b0;
    @(posedge i_clk); // the last acceptance is queued by now
    while (q_dat.size() != 0 && n < 200) begin
      @(posedge i_clk);
      n++;
    end
    if (q_dat.size() != 0) begin
      $display("%s: %0d results never came out", name, q_dat.size());
      err_cnt++;
    end
    $display("%s finished with %0d errors", name, err_cnt - errs0);
  endtask

  initial begin
    int e;
    secp256k1_pkg::fe_t pm1;
    i_rst = 1'b1;
    i_val = 1'b0;
    i_op  = fe_op_pkg::OP_MUL;
    i_a   = '0;
    i_b   = '0;
    i_ctl = '0;
    i_err = 1'b0;
    i_rdy = 1'b1;
    pm1 = secp256k1_pkg::p_eq - 1'b1;
    repeat (3) @(posedge i_clk);
    i_rst <= 1'b0;
    @(posedge i_clk);
    assert (!o_val && !o_err && o_rdy) else begin
      $display("outputs are not idle after reset");
      err_cnt++;
    end
    e = err_cnt;
    issue(fe_op_pkg::OP_MUL, 256'd3, 256'd5, 1'b0);
    end_test("reset and latency", e);
    e = err_cnt;
    issue(fe_op_pkg::OP_MUL, '0, rand_fe(), 1'b0);
    issue(fe_op_pkg::OP_MUL, 256'd1, rand_fe(), 1'b0);
    issue(fe_op_pkg::OP_MUL, pm1, pm1, 1'b0);
    repeat (40) issue(fe_op_pkg::OP_MUL, rand_fe(), rand_fe(), 1'b0);
    end_test("multiply", e);
    e = err_cnt;
    issue(fe_op_pkg::OP_ADD, pm1, pm1, 1'b0); // wraps past p
    issue(fe_op_pkg::OP_ADD, pm1, 256'd1, 1'b0);
    issue(fe_op_pkg::OP_SUB, '0, 256'd1, 1'b0); // goes negative
    issue(fe_op_pkg::OP_SUB, 256'd5, pm1, 1'b0);
    repeat (36) begin
      rng = xorshift32(rng);
      issue(rng[0] ? fe_op_pkg::OP_SUB : fe_op_pkg::OP_ADD, rand_fe(), rand_fe(), 1'b0);
    end
    end_test("add and subtract", e);
    e = err_cnt;
    repeat (40) begin
      rng = xorshift32(rng);
      issue(fe_op_pkg::fe_op_e'(rng[1:0] % 2'd3), rand_fe(), rand_fe(), 1'b0);
    end
    end_test("mixed back to back", e);
    e = err_cnt;
    rdy_rand = 1'b1;
    lat_chk = 1'b0;
    repeat (60) begin
      rng = xorshift32(rng);
      issue(fe_op_pkg::fe_op_e'(rng[1:0] % 2'd3), rand_fe(), rand_fe(), 1'b0);
    end
    end_test("random back-pressure", e);
    rdy_rand = 1'b0;
    lat_chk = 1'b1;
    e = err_cnt;
    issue(fe_op_pkg::OP_MUL, secp256k1_pkg::p_eq, 256'd1, 1'b0);
    issue(fe_op_pkg::OP_ADD, '1, 256'd2, 1'b0);
    issue(fe_op_pkg::OP_SUB, 256'd3, secp256k1_pkg::p_eq, 1'b0);
    issue(fe_op_pkg::OP_MUL, 256'd3, 256'd4, 1'b1);
    issue(fe_op_pkg::OP_ADD, 256'd3, 256'd4, 1'b1);
    issue(fe_op_pkg::OP_SUB, 256'd4, 256'd3, 1'b1);
    end_test("error flags", e);
    $display("checks %0d errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin
    #((N_OPS + STALL_CYC + 20) * 20);
    $display("watchdog expired, the DUT stopped producing results");
    $display("=== FAIL ===");
    $finish;
  end

endmodule

// File: fe_alu_top.sv
// top level of the secp256k1 field unit with multiply path, add/subtract path and merge
`include "fe_defs.svh"

module fe_alu_top #(
  parameter int USE_MULT = `FE_USE_MULT,
  parameter int CTL_BITS = `FE_CTL_BITS
) (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic                  i_val,
  input  fe_op_pkg::fe_op_e     i_op,
  input  secp256k1_pkg::fe_t    i_a,
  input  secp256k1_pkg::fe_t    i_b,
  input  logic [CTL_BITS-1:0]   i_ctl,
  input  logic                  i_err,
  input  logic                  i_rdy,
  output logic                  o_rdy,  // same as the advance strobe
  output logic                  o_val,
  output secp256k1_pkg::fe_t    o_dat,
  output logic [CTL_BITS-1:0]   o_ctl,
  output logic                  o_err
);

  logic                  adv;
  logic                  mul_val, as_val;
  logic                  mul_err, as_err;
  secp256k1_pkg::fe_t    mul_dat, as_dat;
  logic [CTL_BITS-1:0]   mul_ctl, as_ctl;

  assign o_rdy = adv;

  fe_mul_path #(.USE_MULT(USE_MULT), .CTL_BITS(CTL_BITS)) u_mul (
    .i_clk (i_clk),  .i_rst (i_rst),  .i_en  (adv),
    .i_val (i_val & (i_op == fe_op_pkg::OP_MUL)), // only multiplies enter here
    .i_a   (i_a),    .i_b   (i_b),    .i_ctl (i_ctl),  .i_err (i_err),
    .o_val (mul_val), .o_dat (mul_dat), .o_ctl (mul_ctl), .o_err (mul_err)
  );

  fe_addsub_path #(.CTL_BITS(CTL_BITS)) u_addsub (
    .i_clk (i_clk),  .i_rst (i_rst),  .i_en  (adv),
    .i_val (i_val & (i_op != fe_op_pkg::OP_MUL)),
    .i_sub (i_op == fe_op_pkg::OP_SUB),
    .i_a   (i_a),    .i_b   (i_b),    .i_ctl (i_ctl),  .i_err (i_err),
    .o_val (as_val), .o_dat (as_dat), .o_ctl (as_ctl), .o_err (as_err)
  );

  fe_result_merge #(.CTL_BITS(CTL_BITS)) u_merge (
    .i_clk     (i_clk),   .i_rst     (i_rst),
    .i_mul_val (mul_val), .i_mul_dat (mul_dat), .i_mul_ctl (mul_ctl), .i_mul_err (mul_err),
    .i_as_val  (as_val),  .i_as_dat  (as_dat),  .i_as_ctl  (as_ctl),  .i_as_err  (as_err),
    .i_rdy     (i_rdy),
    .o_adv     (adv),
    .o_val     (o_val),   .o_dat     (o_dat),   .o_ctl     (o_ctl),   .o_err     (o_err)
  );

endmodule

// File: fe_result_merge.sv
// output register that merges both path results and makes the pipeline advance strobe
`include "fe_defs.svh"

module fe_result_merge #(
  parameter int CTL_BITS = `FE_CTL_BITS
) (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic                  i_mul_val,
  input  secp256k1_pkg::fe_t    i_mul_dat,
  input  logic [CTL_BITS-1:0]   i_mul_ctl,
  input  logic                  i_mul_err,
  input  logic                  i_as_val,
  input  secp256k1_pkg::fe_t    i_as_dat,
  input  logic [CTL_BITS-1:0]   i_as_ctl,
  input  logic                  i_as_err,
  input  logic                  i_rdy,  // downstream can take a result
  output logic                  o_adv,  // whole pipeline moves when high
  output logic                  o_val,
  output secp256k1_pkg::fe_t    o_dat,
  output logic [CTL_BITS-1:0]   o_ctl,
  output logic                  o_err
);

  // the output register is free when empty or being drained this cycle
  assign o_adv = ~o_val | i_rdy;

  always_ff @(posedge i_clk) begin
    if (o_adv) begin
      o_dat <= i_mul_val ? i_mul_dat : i_as_dat; // equal latency keeps issue order
      o_ctl <= i_mul_val ? i_mul_ctl : i_as_ctl;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_val <= 1'b0;
      o_err <= 1'b0;
    end else if (o_adv) begin
      o_val <= i_mul_val | i_as_val;
      // a collision of both paths means the pipeline lost sync
      o_err <= (i_mul_val & i_mul_err) | (i_as_val & i_as_err) | (i_mul_val & i_as_val);
    end
  end

endmodule

// File: fe_addsub_path.sv
// modular add and subtract, padded to four stages to match the multiply path
`include "fe_defs.svh"

module fe_addsub_path #(
  parameter int CTL_BITS = `FE_CTL_BITS
) (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic                  i_en,  // shared pipeline advance
  input  logic                  i_val, // already qualified by op code at the top
  input  logic                  i_sub, // 1 selects a - b
  input  secp256k1_pkg::fe_t    i_a,
  input  secp256k1_pkg::fe_t    i_b,
  input  logic [CTL_BITS-1:0]   i_ctl,
  input  logic                  i_err,
  output logic                  o_val,
  output secp256k1_pkg::fe_t    o_dat,
  output logic [CTL_BITS-1:0]   o_ctl,
  output logic                  o_err
);

  logic [256:0]          s1_sum; // bit 256 is the carry, or the borrow for a subtract
  logic                  s1_sub;
  logic                  s1_val, s2_val, s3_val;
  logic                  s1_err, s2_err, s3_err;
  logic [CTL_BITS-1:0]   s1_ctl, s2_ctl, s3_ctl;
  secp256k1_pkg::fe_t    s2_dat, s3_dat;
  secp256k1_pkg::fe_t    corr;   // stage 2 result before it is registered

  // a sum lies below 2p and a difference above -p, so one correction is enough
  always_comb begin
    if (s1_sub) begin
      corr = s1_sum[256] ? s1_sum[255:0] + secp256k1_pkg::p_eq : s1_sum[255:0];
    end else begin
      corr = (s1_sum >= {1'b0, secp256k1_pkg::p_eq}) ?
             s1_sum[255:0] - secp256k1_pkg::p_eq : s1_sum[255:0];
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_en) begin
      s1_sum <= i_sub ? {1'b0, i_a} - {1'b0, i_b} : {1'b0, i_a} + {1'b0, i_b};
      s1_sub <= i_sub;
      s1_ctl <= i_ctl;
      s2_dat <= corr;
      s2_ctl <= s1_ctl;
      s3_dat <= s2_dat; // stages 3 and 4 only delay
      s3_ctl <= s2_ctl;
      o_dat  <= s3_dat;
      o_ctl  <= s3_ctl;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      {s1_val, s2_val, s3_val, o_val} <= '0;
      {s1_err, s2_err, s3_err, o_err} <= '0;
    end else if (i_en) begin
      s1_val <= i_val;
      s1_err <= i_err | (i_a >= secp256k1_pkg::p_eq) | (i_b >= secp256k1_pkg::p_eq);
      s2_val <= s1_val;
      s2_err <= s1_err;
      s3_val <= s2_val;
      s3_err <= s2_err;
      o_val  <= s3_val;
      o_err  <= s3_err;
    end
  end

endmodule

// File: fe_mul_path.sv
// multiply path with the full-width product register ahead of the reducer
`include "fe_defs.svh"

module fe_mul_path #(
  parameter int USE_MULT = `FE_USE_MULT,
  parameter int CTL_BITS = `FE_CTL_BITS
) (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic                  i_en,  // shared pipeline advance
  input  logic                  i_val, // already qualified by OP_MUL at the top
  input  secp256k1_pkg::fe_t    i_a,
  input  secp256k1_pkg::fe_t    i_b,
  input  logic [CTL_BITS-1:0]   i_ctl,
  input  logic                  i_err,
  output logic                  o_val,
  output secp256k1_pkg::fe_t    o_dat,
  output logic [CTL_BITS-1:0]   o_ctl,
  output logic                  o_err
);

  secp256k1_pkg::wide_u  prod;     // stage 1 product
  logic                  prod_val;
  logic                  prod_err; // input error or an operand out of range
  logic [CTL_BITS-1:0]   prod_ctl;

  always_ff @(posedge i_clk) begin
    if (i_en) begin
      prod.flat <= {256'b0, i_a} * {256'b0, i_b}; // full 512-bit product
      prod_ctl  <= i_ctl;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      prod_val <= 1'b0;
      prod_err <= 1'b0;
    end else if (i_en) begin
      prod_val <= i_val;
      // operands of p or more are passed on unchanged but marked bad
      prod_err <= i_err | (i_a >= secp256k1_pkg::p_eq) | (i_b >= secp256k1_pkg::p_eq);
    end
  end

  secp256k1_mod #(.USE_MULT(USE_MULT), .CTL_BITS(CTL_BITS)) u_mod (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_en  (i_en),
    .i_dat (prod),
    .i_val (prod_val),
    .i_err (prod_err),
    .i_ctl (prod_ctl),
    .o_dat (o_dat),
    .o_val (o_val),
    .o_err (o_err),
    .o_ctl (o_ctl)
  );

endmodule

// File: secp256k1_mod.sv
// three-stage reduction of a 512-bit product modulo p by two folds and a final subtract
`include "fe_defs.svh"

module secp256k1_mod #(
  parameter int USE_MULT = `FE_USE_MULT,
  parameter int CTL_BITS = `FE_CTL_BITS
) (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic                  i_en,   // pipeline advance from the output stage
  input  secp256k1_pkg::wide_u  i_dat,  // product, below p^2 for legal operands
  input  logic                  i_val,
  input  logic                  i_err,
  input  logic [CTL_BITS-1:0]   i_ctl,
  output secp256k1_pkg::fe_t    o_dat,
  output logic                  o_val,
  output logic                  o_err,  // also set if the folded value is still 2p or more
  output logic [CTL_BITS-1:0]   o_ctl
);

  // 2p as a 512-bit constant for the overflow check
  localparam logic [511:0] two_p = {255'b0, secp256k1_pkg::p_eq, 1'b0};

  secp256k1_pkg::wide_u res0; // after the first fold
  secp256k1_pkg::wide_u res1; // after the second fold, below 2^256 + small
  logic [1:0] val; // valid for res0 and res1
  logic [1:0] err;
  logic [1:0][CTL_BITS-1:0] ctl; // tags ride alongside, no reset

  // hi * 2^256 + lo is congruent to hi * (2^32 + 977) + lo
  function automatic logic [511:0] fold(input secp256k1_pkg::wide_u w);
    logic [511:0] hi_w;
    logic [511:0] lo_w;
    hi_w = {256'b0, w.half.hi};
    lo_w = {256'b0, w.half.lo};
    if (USE_MULT != 0) begin
      fold = hi_w * {256'b0, secp256k1_pkg::fold_c} + lo_w; // lets the tool map to DSPs
    end else begin
      fold = (hi_w << 32) + (hi_w << 9) + (hi_w << 8) + (hi_w << 7) // 977 = 0x3d1
           + (hi_w << 6) + (hi_w << 4) + hi_w + lo_w;
    end
  endfunction

  always_ff @(posedge i_clk) begin
    if (i_en) begin
      res0.flat <= fold(i_dat); // stage 1 of the reducer
      res1.flat <= fold(res0);  // stage 2, hi is now at most 33 bits wide
      ctl       <= {ctl[0], i_ctl};
      o_ctl     <= ctl[1];
      // stage 3 subtracts p once, the low half holds the answer
      o_dat     <= (res1.flat >= {256'b0, secp256k1_pkg::p_eq}) ?
                   res1.half.lo - secp256k1_pkg::p_eq : res1.half.lo;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      val   <= '0;
      err   <= '0;
      o_val <= 1'b0;
      o_err <= 1'b0;
    end else if (i_en) begin
      val   <= {val[0], i_val};
      err   <= {err[0], i_err};
      o_val <= val[1];
      o_err <= err[1] | (res1.flat >= two_p); // one subtract cannot fix this case
    end
  end

endmodule

// File: fe_op_pkg.sv
// operation code enum for the field arithmetic unit
package fe_op_pkg;

  // the encoding 2'b11 is unused and falls into the add/subtract path as an add
  typedef enum logic [1:0] {
    OP_MUL = 2'b00, // a * b mod p
    OP_ADD = 2'b01, // a + b mod p
    OP_SUB = 2'b10  // a - b mod p
  } fe_op_e;

endpackage

// File: secp256k1_pkg.sv
// field element type, wide product union, prime and fold constants for secp256k1
package secp256k1_pkg;

  typedef logic [255:0] fe_t; // one field element

  // a 512-bit product seen flat or split into halves for the fold
  typedef struct packed {
    fe_t hi; // upper 256 bits, multiplied by the fold constant
    fe_t lo; // lower 256 bits, added straight in
  } wide_half_t;

  typedef union packed {
    logic [511:0] flat; // whole word for compares against p
    wide_half_t   half; // hi/lo view for the fold
  } wide_u;

  // p = 2^256 - 2^32 - 977
  localparam fe_t p_eq =
    256'hFFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFE_FFFFFC2F;

  // 2^256 mod p, so hi * 2^256 folds down to hi * fold_c
  localparam fe_t fold_c = 256'h1_0000_03D1;

endpackage

// File: fe_defs.svh
// shared width and build option macros for the field arithmetic unit
`ifndef FE_DEFS_SVH
`define FE_DEFS_SVH

// control tag width carried next to every operation
`define FE_CTL_BITS 8

// reducer fold style, 1 picks the multiplier operator and 0 the shift-add sum
`define FE_USE_MULT 0

`endif
